/* pers_defines.svh */
// shared sizes and instruction field positions, include wherever a width or field is needed
`ifndef PERS_DEFINES_SVH
`define PERS_DEFINES_SVH

// ----------------------------------------------------------
// register file geometry
// ----------------------------------------------------------
`define PERS_AEG_CNT       51   // implemented AEGs
`define PERS_AEG_IDX_BITS  6    // bits needed to address 0..50
`define PERS_NQ_AEG        8    // takes the engine next-queue count
`define PERS_ARG_AEGS      8    // AEG 0..7 go to the engine

// ----------------------------------------------------------
// widths
// ----------------------------------------------------------
`define PERS_WORD_W        64
`define PERS_INST_W        32
`define PERS_EXC_W         16
`define PERS_AEG_CNT_W     18

// ----------------------------------------------------------
// instruction fields
// ----------------------------------------------------------
`define PERS_KIND_HI       31
`define PERS_KIND_LO       30
`define PERS_CAEP_HI       22   // custom instruction number
`define PERS_CAEP_LO       18
`define PERS_IDX_HI        17   // full AEG index, wider than the file
`define PERS_IDX_LO        0

// exception vector bits
`define PERS_EXC_UNIMPL    0
`define PERS_EXC_AEGIDX    1

`endif

/* pers_isa_pkg.sv */
// instruction side types, used by the decoder and the top level through scoped names
`include "pers_defines.svh"

package pers_isa_pkg;

   // ----------------------------------------------------------
   // instruction word and its fields
   // ----------------------------------------------------------
   typedef logic [`PERS_INST_W-1:0] inst_t;   // raw host instruction

   typedef logic [`PERS_KIND_HI-`PERS_KIND_LO:0] inst_kind_t;   // selects the operation

   typedef logic [`PERS_CAEP_HI-`PERS_CAEP_LO:0] caep_t;   // caep number, only 0 implemented

   // index as the host sends it
   // upper bits must be zero for a legal access
   typedef logic [`PERS_IDX_HI-`PERS_IDX_LO:0] aeg_idx_t;

   // ----------------------------------------------------------
   // kind encodings
   // ----------------------------------------------------------
   localparam inst_kind_t KIND_AEG_WR = 2'd1;   // aeg <- dispatch data
   localparam inst_kind_t KIND_AEG_RD = 2'd2;   // aeg -> return data
   localparam inst_kind_t KIND_CAEP   = 2'd3;   // custom, number in caep field
   // kind 0 is left unimplemented

endpackage

/* pers_data_pkg.sv */
// data side types for register contents, return path and engine arguments
`include "pers_defines.svh"

package pers_data_pkg;

   // ----------------------------------------------------------
   // payload types
   // ----------------------------------------------------------
   typedef logic [`PERS_WORD_W-1:0] word_t;   // dispatch data, one aeg

   typedef logic [`PERS_EXC_W-1:0] exc_t;   // only bits 0 and 1 used

   // aeg 0 sits in the lowest word
   typedef logic [`PERS_ARG_AEGS*`PERS_WORD_W-1:0] graph_args_t;

   typedef logic [`PERS_AEG_CNT_W-1:0] aeg_cnt_t;   // reported aeg count

endpackage

/* inst_decode.sv */
// instruction decoder, turns each valid host instruction into aeg and caep strobes
`timescale 1ns/1ps
`include "pers_defines.svh"

module inst_decode (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  pers_isa_pkg::inst_t     inst_i,
   input  logic                    inst_vld_i,
   output logic                    aeg_wr_o,
   output logic                    aeg_rd_o,
   output pers_isa_pkg::aeg_idx_t  aeg_idx_o,
   output logic                    caep0_o,
   output logic                    err_unimpl_o
);

   // ----------------------------------------------------------
   // field extraction
   // ----------------------------------------------------------
   pers_isa_pkg::inst_kind_t kind;
   pers_isa_pkg::caep_t      caep;
   logic                     unimpl;   // current cycle, not yet registered
   logic                     err_unimpl_q;

   assign kind      = inst_i[`PERS_KIND_HI:`PERS_KIND_LO];
   assign caep      = inst_i[`PERS_CAEP_HI:`PERS_CAEP_LO];
   assign aeg_idx_o = inst_i[`PERS_IDX_HI:`PERS_IDX_LO];   // range check is in aeg_file

   // strobes live in the issue cycle only
   always_comb begin
      aeg_wr_o = 1'b0;
      aeg_rd_o = 1'b0;
      caep0_o  = 1'b0;
      unimpl   = 1'b0;
      if (inst_vld_i) begin
         case (kind)
            pers_isa_pkg::KIND_AEG_WR: aeg_wr_o = 1'b1;
            pers_isa_pkg::KIND_AEG_RD: aeg_rd_o = 1'b1;
            pers_isa_pkg::KIND_CAEP: begin
               caep0_o = (caep == '0);   // caep 0 starts the engine
               unimpl  = (caep != '0);   // nothing else behind the other numbers
            end
            default: unimpl = 1'b1;   // kind 0
         endcase
      end
   end

   // ----------------------------------------------------------
   // error pulse, one cycle after the instruction
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         err_unimpl_q <= 1'b0;
      end else begin
         err_unimpl_q <= unimpl;
      end
   end

   assign err_unimpl_o = err_unimpl_q;

   // at most one strobe per cycle
   a_one_action : assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0({aeg_wr_o, aeg_rd_o, caep0_o}));

endmodule

/* aeg_file.sv */
// application engine register file, host access, done capture and read return path
`timescale 1ns/1ps
`include "pers_defines.svh"

module aeg_file (
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  logic                        aeg_wr_i,
   input  logic                        aeg_rd_i,
   input  pers_isa_pkg::aeg_idx_t      aeg_idx_i,
   input  pers_data_pkg::word_t        wr_data_i,
   input  logic                        engine_done_i,
   input  pers_data_pkg::word_t        engine_nq_count_i,
   output pers_data_pkg::word_t        ret_data_o,
   output logic                        ret_vld_o,
   output logic                        err_aegidx_o,
   output pers_data_pkg::graph_args_t  graph_args_o
);

   // ----------------------------------------------------------
   // index check and select
   // ----------------------------------------------------------
   logic                          idx_ok;   // index below aeg count
   logic                          wr_ok;
   logic                          rd_ok;
   logic [`PERS_AEG_IDX_BITS-1:0] aeg_sel;   // low bits, only used when idx_ok

   assign idx_ok  = (aeg_idx_i < `PERS_AEG_CNT);   // full 18 bit compare
   assign wr_ok   = aeg_wr_i && idx_ok;
   assign rd_ok   = aeg_rd_i && idx_ok;
   assign aeg_sel = aeg_idx_i[`PERS_AEG_IDX_BITS-1:0];

   // current register values, one word per aeg
   pers_data_pkg::word_t aeg_w [`PERS_AEG_CNT];

   // ----------------------------------------------------------
   // register entries
   // ----------------------------------------------------------
   genvar g;
   generate
      for (g = 0; g < `PERS_AEG_CNT; g++) begin : g_aeg
         localparam logic [`PERS_AEG_IDX_BITS-1:0] SEL = g;

         logic                 wr_hit;   // host write to this entry
         pers_data_pkg::word_t aeg_q;

         assign wr_hit  = wr_ok && (aeg_sel == SEL);

         always_ff @(posedge clk) begin
            if (!rst_n_i) begin
               aeg_q <= '0;
            end else if (wr_hit) begin
               aeg_q <= wr_data_i;   // host wins over done
            end else if ((g == `PERS_NQ_AEG) && engine_done_i) begin
               aeg_q <= engine_nq_count_i;   // engine count capture
            end
         end

         assign aeg_w[g] = aeg_q;
      end

      // aeg 0..7 straight out as engine arguments
      for (g = 0; g < `PERS_ARG_AEGS; g++) begin : g_args
         assign graph_args_o[g*`PERS_WORD_W +: `PERS_WORD_W] = aeg_w[g];
      end
   endgenerate

   // ----------------------------------------------------------
   // read return and index error, both one cycle later
   // ----------------------------------------------------------
   pers_data_pkg::word_t ret_data_q;
   logic                 ret_vld_q;
   logic                 err_aegidx_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ret_vld_q    <= 1'b0;
         err_aegidx_q <= 1'b0;
      end else begin
         ret_vld_q    <= rd_ok;
         err_aegidx_q <= (aeg_wr_i || aeg_rd_i) && !idx_ok;
      end
   end

   // old value is returned, a same cycle write lands after the sample
   always_ff @(posedge clk) begin
      if (rd_ok) begin
         ret_data_q <= aeg_w[aeg_sel];
      end
   end

   assign ret_data_o   = ret_data_q;
   assign ret_vld_o    = ret_vld_q;
   assign err_aegidx_o = err_aegidx_q;

   // a cycle gives either a return or an index error
   a_ret_xor_err : assert property (@(posedge clk) disable iff (!rst_n_i)
      !(ret_vld_o && err_aegidx_o));

   // every return comes one cycle after a read
   a_ret_source : assert property (@(posedge clk) disable iff (!rst_n_i)
      ret_vld_o |-> $past(aeg_rd_i));

endmodule

/* dispatch_ctrl.sv */
// dispatch control, starts the graph engine on caep 0 and holds the host while it runs
`timescale 1ns/1ps
`include "pers_defines.svh"

module dispatch_ctrl (
   input  logic clk,
   input  logic rst_n_i,
   input  logic caep0_i,
   input  logic engine_busy_i,
   output logic start_o,
   output logic stall_o,
   output logic idle_o
);

   // ----------------------------------------------------------
   // start pulse
   // ----------------------------------------------------------
   logic start_q;   // caep 0 seen last cycle

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         start_q <= 1'b0;
      end else begin
         start_q <= caep0_i;
      end
   end

   assign start_o = start_q;   // one cycle after the instruction

   // ----------------------------------------------------------
   // host side levels
   // ----------------------------------------------------------
   // stall covers the issue cycle, the start cycle and the busy window
   assign stall_o = caep0_i || start_q || engine_busy_i;

   // idle drops from the start cycle on, the issue cycle still reads idle
   assign idle_o  = !start_q && !engine_busy_i;

   // stall and idle overlap only in the caep 0 issue cycle
   // and idle is gone in the following one
   a_stall_idle : assert property (@(posedge clk) disable iff (!rst_n_i)
      (stall_o && idle_o) |-> caep0_i ##1 (start_o && !idle_o));

endmodule

/* pers_top.sv */
// personality top level, connects decoder, aeg file and dispatch control to host and engine
`timescale 1ns/1ps
`include "pers_defines.svh"

module pers_top (
   input  logic                        clk,
   input  logic                        rst_n_i,

   // host dispatch side
   input  pers_isa_pkg::inst_t         inst_i,
   input  pers_data_pkg::word_t        data_i,
   input  logic                        inst_vld_i,

   // graph engine status
   input  logic                        engine_busy_i,
   input  logic                        engine_done_i,
   input  pers_data_pkg::word_t        engine_nq_count_i,

   // host return side
   output pers_data_pkg::word_t        ret_data_o,
   output logic                        ret_vld_o,
   output pers_data_pkg::exc_t         exception_o,
   output pers_data_pkg::aeg_cnt_t     aeg_cnt_o,

   // engine control
   output logic                        start_o,
   output logic                        stall_o,
   output logic                        idle_o,
   output pers_data_pkg::graph_args_t  graph_args_o
);

   // ----------------------------------------------------------
   // decode
   // ----------------------------------------------------------
   logic                   aeg_wr;
   logic                   aeg_rd;
   pers_isa_pkg::aeg_idx_t aeg_idx;
   logic                   caep0;
   logic                   err_unimpl;   // registered in the decoder
   logic                   err_aegidx;   // registered in the aeg file

   inst_decode u_inst_decode (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .inst_i       (inst_i),
      .inst_vld_i   (inst_vld_i),
      .aeg_wr_o     (aeg_wr),
      .aeg_rd_o     (aeg_rd),
      .aeg_idx_o    (aeg_idx),
      .caep0_o      (caep0),
      .err_unimpl_o (err_unimpl)
   );

   // ----------------------------------------------------------
   // registers
   // ----------------------------------------------------------
   aeg_file u_aeg_file (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .aeg_wr_i          (aeg_wr),
      .aeg_rd_i          (aeg_rd),
      .aeg_idx_i         (aeg_idx),
      .wr_data_i         (data_i),   // dispatch data is the write payload
      .engine_done_i     (engine_done_i),
      .engine_nq_count_i (engine_nq_count_i),
      .ret_data_o        (ret_data_o),
      .ret_vld_o         (ret_vld_o),
      .err_aegidx_o      (err_aegidx),
      .graph_args_o      (graph_args_o)
   );

   // ----------------------------------------------------------
   // engine start, stall and idle
   // ----------------------------------------------------------
   dispatch_ctrl u_dispatch_ctrl (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .caep0_i       (caep0),
      .engine_busy_i (engine_busy_i),
      .start_o       (start_o),
      .stall_o       (stall_o),
      .idle_o        (idle_o)
   );

   // exception vector, unused bits stay zero
   always_comb begin
      exception_o                  = '0;
      exception_o[`PERS_EXC_UNIMPL] = err_unimpl;
      exception_o[`PERS_EXC_AEGIDX] = err_aegidx;
   end

   assign aeg_cnt_o = pers_data_pkg::aeg_cnt_t'(`PERS_AEG_CNT);   // fixed file size

   // one instruction per cycle, so its outcome is a single event
   // in the cycle after it: return, one exception or none
   a_one_outcome : assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0({ret_vld_o, err_unimpl, err_aegidx, start_o}));

endmodule

/* tb_pers_top.sv */
// self-checking testbench for pers_top, run with the sources in build.f and top tb_pers_top
`timescale 1ns/1ps
`include "pers_defines.svh"

module tb_pers_top;

   localparam int CLK_HALF    = 4;      // 8 ns period
   localparam int CYCLE_LIMIT = 2000;   // tests need about 350 cycles, wide margin

   logic                              clk;
   logic                              rst_n_i;
   pers_isa_pkg::inst_t               inst_i;
   pers_data_pkg::word_t              data_i;
   logic                              inst_vld_i;
   logic                              engine_busy_i;
   logic                              engine_done_i;
   pers_data_pkg::word_t              engine_nq_count_i;
   pers_data_pkg::word_t              ret_data_o;
   logic                              ret_vld_o;
   pers_data_pkg::exc_t               exception_o;
   pers_data_pkg::aeg_cnt_t           aeg_cnt_o;
   logic                              start_o;
   logic                              stall_o;
   logic                              idle_o;
   pers_data_pkg::graph_args_t        graph_args_o;

   pers_top DUT (.*);

   always #CLK_HALF clk = ~clk;

   // ----------------------------------------------------------
   // reference state and per cycle expectations
   // ----------------------------------------------------------
   pers_data_pkg::word_t model [`PERS_AEG_CNT];   // expected aeg contents
   integer               seed;
   int                   cycle_cnt;
   int                   chk_cnt;
   int                   err_cnt;
   int                   test_chk0;   // counts at test start
   int                   test_err0;
   string                test_name;
   logic                 chk_en;

   logic                 iss_vld;   // instruction presented this cycle
   logic                 iss_c0;
   pers_data_pkg::word_t iss_data;
   pers_data_pkg::exc_t  iss_exc;
   logic                 prv_vld;   // same, one cycle back
   logic                 prv_c0;
   pers_data_pkg::word_t prv_data;
   pers_data_pkg::exc_t  prv_exc;
   logic                 exp_stall;
   logic                 exp_idle;

   // expected outcome of one cycle, updates the aeg model
   function automatic void ref_step(input logic vld, input pers_isa_pkg::inst_t inst,
         input pers_data_pkg::word_t data, input logic done, input pers_data_pkg::word_t count,
         output logic rvld, output pers_data_pkg::word_t rdata,
         output pers_data_pkg::exc_t exc, output logic c0);
      logic [1:0]  kind;
      logic [4:0]  caep;
      logic [17:0] idx;
      logic        idx_ok;
      logic        wr8;   // host write to the count aeg
      kind   = inst[`PERS_KIND_HI:`PERS_KIND_LO];
      caep   = inst[`PERS_CAEP_HI:`PERS_CAEP_LO];
      idx    = inst[`PERS_IDX_HI:`PERS_IDX_LO];
      idx_ok = (idx < `PERS_AEG_CNT);
      rvld   = 1'b0;
      rdata  = '0;
      exc    = '0;
      c0     = 1'b0;
      wr8    = vld && (kind == 2'd1) && (idx == `PERS_NQ_AEG);
      if (vld) begin
         case (kind)
            2'd1: begin
               if (idx_ok) begin
                  model[idx] = data;
               end else begin
                  exc[`PERS_EXC_AEGIDX] = 1'b1;
               end
            end
            2'd2: begin
               if (idx_ok) begin
                  rvld  = 1'b1;
                  rdata = model[idx];   // old value, capture lands after
               end else begin
                  exc[`PERS_EXC_AEGIDX] = 1'b1;
               end
            end
            2'd3: begin
               if (caep == 5'd0) begin
                  c0 = 1'b1;
               end else begin
                  exc[`PERS_EXC_UNIMPL] = 1'b1;
               end
            end
            default: exc[`PERS_EXC_UNIMPL] = 1'b1;
         endcase
      end
      if (done && !wr8) model[`PERS_NQ_AEG] = count;   // host write wins
   endfunction

   function automatic pers_isa_pkg::inst_t mk_inst(input logic [1:0] kind,
         input logic [4:0] caep, input logic [17:0] idx);
      pers_isa_pkg::inst_t inst;
      inst = '0;
      inst[`PERS_KIND_HI:`PERS_KIND_LO] = kind;
      inst[`PERS_CAEP_HI:`PERS_CAEP_LO] = caep;
      inst[`PERS_IDX_HI:`PERS_IDX_LO]   = idx;
      return inst;
   endfunction

   function automatic pers_data_pkg::word_t rand64();
      return {$random(seed), $random(seed)};
   endfunction

   task automatic check_val(input string what, input logic [511:0] exp, input logic [511:0] act);
      chk_cnt++;
      assert (act === exp) else begin
         $display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   // ----------------------------------------------------------
   // compare process, outputs are settled at the falling edge
   // ----------------------------------------------------------
   always @(negedge clk) begin
      if (chk_en) begin
         exp_stall = iss_c0 || prv_c0 || engine_busy_i;
         exp_idle  = !prv_c0 && !engine_busy_i;
         check_val("ret_vld", prv_vld, ret_vld_o);
         if (prv_vld) check_val("ret_data", prv_data, ret_data_o);
         check_val("exception", prv_exc, exception_o);
         check_val("start", prv_c0, start_o);
         check_val("stall", exp_stall, stall_o);
         check_val("idle", exp_idle, idle_o);
      end
      prv_vld  = iss_vld;   // shift, then clear for the next cycle
      prv_c0   = iss_c0;
      prv_data = iss_data;
      prv_exc  = iss_exc;
      iss_vld  = 1'b0;
      iss_c0   = 1'b0;
      iss_data = '0;
      iss_exc  = '0;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   // ----------------------------------------------------------
   // stimulus helpers
   // ----------------------------------------------------------
   task automatic issue(input logic vld, input pers_isa_pkg::inst_t inst,
         input pers_data_pkg::word_t data, input logic done, input pers_data_pkg::word_t count);
      logic                 v;
      pers_data_pkg::word_t d;
      pers_data_pkg::exc_t  e;
      logic                 c;
      @(posedge clk);
      inst_i            <= inst;
      data_i            <= data;
      inst_vld_i        <= vld;
      engine_done_i     <= done;
      engine_nq_count_i <= count;
      ref_step(vld, inst, data, done, count, v, d, e, c);
      iss_vld  = v;
      iss_data = d;
      iss_exc  = e;
      iss_c0   = c;
   endtask

   task automatic write_aeg(input logic [17:0] idx, input pers_data_pkg::word_t d);
      issue(1'b1, mk_inst(2'd1, 5'd0, idx), d, 1'b0, '0);
   endtask

   task automatic read_aeg(input logic [17:0] idx);
      issue(1'b1, mk_inst(2'd2, 5'd0, idx), rand64(), 1'b0, '0);
   endtask

   task automatic idle(input int n);
      repeat (n) issue(1'b0, '0, '0, 1'b0, '0);
   endtask

   task automatic set_busy(input logic b);
      engine_busy_i <= b;   // applies to the cycle just issued
      idle(1);
   endtask

   task automatic check_args();
      pers_data_pkg::graph_args_t exp;
      for (int k = 0; k < `PERS_ARG_AEGS; k++) exp[k*`PERS_WORD_W +: `PERS_WORD_W] = model[k];
      @(negedge clk);
      check_val("graph_args", exp, graph_args_o);
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_chk0 = chk_cnt;
      test_err0 = err_cnt;
   endtask

   task automatic end_test();
      idle(2);   // drain the last return
      $display("test %s done: %0d checks, %0d errors", test_name,
               chk_cnt - test_chk0, err_cnt - test_err0);
   endtask

   // ----------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------
   initial begin
      logic [17:0]          idx;
      pers_data_pkg::word_t cnt;
      clk               = 1'b0;
      rst_n_i           = 1'b0;
      inst_i            = '0;
      data_i            = '0;
      inst_vld_i        = 1'b0;
      engine_busy_i     = 1'b0;
      engine_done_i     = 1'b0;
      engine_nq_count_i = '0;
      seed              = 28346;
      cycle_cnt         = 0;
      chk_cnt           = 0;
      err_cnt           = 0;
      chk_en            = 1'b0;
      iss_vld           = 1'b0;
      iss_c0            = 1'b0;
      iss_data          = '0;
      iss_exc           = '0;
      for (int k = 0; k < `PERS_AEG_CNT; k++) model[k] = '0;
      test_name = "reset";

      repeat (3) @(posedge clk);
      rst_n_i <= 1'b1;
      chk_en = 1'b1;

      begin_test("reset_state");
      check_val("aeg_cnt", `PERS_AEG_CNT, aeg_cnt_o);
      for (int k = 0; k < `PERS_AEG_CNT; k++) read_aeg(k);   // all zero after reset
      end_test();

      begin_test("write_read");
      for (int k = 0; k < `PERS_ARG_AEGS; k++) begin
         write_aeg(k, rand64());
         read_aeg(k);
      end
      repeat (60) begin
         idx = {$random(seed)} % `PERS_AEG_CNT;
         write_aeg(idx, rand64());
         read_aeg(idx);
      end
      idle(1);
      check_args();
      end_test();

      begin_test("bad_index");
      write_aeg(18'd51, rand64());
      write_aeg(18'd64, rand64());   // low bits alias aeg 0
      write_aeg(18'd72, rand64());   // low bits alias aeg 8
      read_aeg(18'd63);
      read_aeg(18'h3ffff);
      for (int k = 0; k < 6; k++) begin
         idx = 18'd51 + ({$random(seed)} % (18'h3ffff - 18'd51));
         if (k % 2 == 0) write_aeg(idx, rand64());
         else read_aeg(idx);
      end
      for (int k = 0; k < `PERS_AEG_CNT; k++) read_aeg(k);   // nothing changed
      end_test();

      begin_test("unimplemented");
      repeat (4) issue(1'b1, mk_inst(2'd0, $random(seed), $random(seed)), rand64(), 1'b0, '0);
      repeat (4) issue(1'b1, mk_inst(2'd3, 5'd1 + ({$random(seed)} % 31), $random(seed)),
                       rand64(), 1'b0, '0);
      for (int k = 0; k < `PERS_AEG_CNT; k++) read_aeg(k);   // no register touched
      idle(1);
      check_args();
      end_test();

      begin_test("caep0_start");
      issue(1'b1, mk_inst(2'd3, 5'd0, $random(seed)), rand64(), 1'b0, '0);
      idle(2);
      issue(1'b1, mk_inst(2'd3, 5'd0, 18'd0), rand64(), 1'b0, '0);
      set_busy(1'b1);   // busy rises in the issue cycle
      idle(6);
      set_busy(1'b0);
      idle(3);
      end_test();

      begin_test("done_capture");
      cnt = rand64();
      issue(1'b0, '0, '0, 1'b1, cnt);   // plain done pulse
      read_aeg(`PERS_NQ_AEG);
      issue(1'b1, mk_inst(2'd1, 5'd0, `PERS_NQ_AEG), rand64(), 1'b1, rand64());
      read_aeg(`PERS_NQ_AEG);
      issue(1'b1, mk_inst(2'd2, 5'd0, `PERS_NQ_AEG), rand64(), 1'b1, rand64());
      read_aeg(`PERS_NQ_AEG);   // sees the capture from the read cycle
      idle(1);
      check_args();
      end_test();

      $display("all tests: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* build.f */
+incdir+.
pers_isa_pkg.sv
pers_data_pkg.sv
inst_decode.sv
aeg_file.sv
dispatch_ctrl.sv
pers_top.sv
tb_pers_top.sv

/* Bender.yml */
package:
  name: pers_dispatch

export_include_dirs:
  - .

sources:
  - pers_isa_pkg.sv
  - pers_data_pkg.sv
  - inst_decode.sv
  - aeg_file.sv
  - dispatch_ctrl.sv
  - pers_top.sv
  - target: simulation
    files:
      - tb_pers_top.sv
